// ==== hdl/data_memory.sv ====
// Single port line RAM; read data lags one cycle and holds during writes, contents not reset
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
	parameter int LINE_ADDR_BITS = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire logic write,
	input wire lsu_pkg::byte_en_t byte_en,
	input wire logic [LINE_ADDR_BITS-1:0] line_addr,
	input wire lsu_pkg::line_t wdata,
	output lsu_pkg::line_t rdata
);
	import lsu_pkg::*;

	localparam int NUM_LINES = 2 ** LINE_ADDR_BITS;

	line_t lines [NUM_LINES];

	// Byte lane writes, enable b covers bits 8b+7 to 8b of the line
	always_ff @(posedge clk)
	begin
		if (req && write)
		begin
			for (int b = 0; b < 64; b++)
			begin
				if (byte_en[b])
					lines[line_addr][b / 4][8 * (b % 4) +: 8] <= wdata[b / 4][8 * (b % 4) +: 8];
			end
		end
	end

	// Registered read port
	always_ff @(posedge clk)
	begin
		if (rst)
			rdata <= '0;
		else if (req && !write)
			rdata <= lines[line_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
// Shared types; a line holds 16 words and word 15 sits at the lowest byte address of the line
`default_nettype none

package lsu_pkg;

	typedef logic [31:0] word_t;
	typedef word_t [15:0] line_t;
	typedef logic [15:0] lane_mask_t;
	typedef logic [3:0] lane_idx_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] mem_op_t;
	// One enable per byte of a line
	typedef logic [63:0] byte_en_t;

	typedef enum logic [1:0]
	{
		KIND_ARITH,
		KIND_LOAD,
		KIND_STORE
	} kind_t;

	typedef struct packed
	{
		logic valid;
		kind_t kind;
		mem_op_t mem_op;
		word_t pc;
		reg_idx_t dest;
		logic is_vector;
		lane_mask_t mask;
		word_t address;
		// Arithmetic result or store data, scalar store data in word 0
		line_t result;
		lane_idx_t reg_lane;
	} issue_t;

	typedef struct packed
	{
		issue_t inst;
		logic collision;
	} ma_out_t;

	typedef struct packed
	{
		logic valid;
		reg_idx_t dest;
		logic is_vector;
		line_t value;
		lane_mask_t mask;
	} wb_out_t;

	// Memory keeps bytes big-endian, registers hold the low address byte in bits 7:0
	function automatic word_t swap_bytes(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic line_t swap_line(line_t l);
		line_t s;
		for (int i = 0; i < 16; i++)
			s[i] = swap_bytes(l[i]);
		return s;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/lsu_top.sv ====
// Load and writeback subsystem; issue to writeback or rollback is 3 cycles with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int LINE_ADDR_BITS = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire lsu_pkg::issue_t issue,
	input wire logic fill_valid,
	input wire logic [LINE_ADDR_BITS-1:0] fill_line_addr,
	input wire lsu_pkg::line_t fill_data,
	output lsu_pkg::wb_out_t wb,
	output logic rollback_valid,
	output lsu_pkg::word_t rollback_pc,
	output logic [31:0] retire_count
);
	import lsu_pkg::*;

	// Access stage to arbiter
	logic lost;
	logic ma_req;
	logic ma_write;
	byte_en_t ma_byte_en;
	logic [LINE_ADDR_BITS-1:0] ma_line_addr;
	line_t ma_wdata;
	ma_out_t ma;

	// Arbiter to memory
	logic mem_req;
	logic mem_write;
	byte_en_t mem_byte_en;
	logic [LINE_ADDR_BITS-1:0] mem_line_addr;
	line_t mem_wdata;
	line_t mem_rdata;

	mem_access_stage #(
		.LINE_ADDR_BITS(LINE_ADDR_BITS)
	) u_access (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.lost(lost),
		.ma_req(ma_req),
		.ma_write(ma_write),
		.ma_byte_en(ma_byte_en),
		.ma_line_addr(ma_line_addr),
		.ma_wdata(ma_wdata),
		.ma(ma)
	);

	mem_arbiter #(
		.LINE_ADDR_BITS(LINE_ADDR_BITS)
	) u_arbiter (
		.clk(clk),
		.rst(rst),
		.ma_req(ma_req),
		.ma_write(ma_write),
		.ma_byte_en(ma_byte_en),
		.ma_line_addr(ma_line_addr),
		.ma_wdata(ma_wdata),
		.fill_valid(fill_valid),
		.fill_line_addr(fill_line_addr),
		.fill_data(fill_data),
		.lost(lost),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_byte_en(mem_byte_en),
		.mem_line_addr(mem_line_addr),
		.mem_wdata(mem_wdata)
	);

	data_memory #(
		.LINE_ADDR_BITS(LINE_ADDR_BITS)
	) u_memory (
		.clk(clk),
		.rst(rst),
		.req(mem_req),
		.write(mem_write),
		.byte_en(mem_byte_en),
		.line_addr(mem_line_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	writeback_stage u_writeback (
		.clk(clk),
		.rst(rst),
		.ma(ma),
		.mem_rdata(mem_rdata),
		.wb(wb),
		.rollback_valid(rollback_valid),
		.rollback_pc(rollback_pc),
		.retire_count(retire_count)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_access_stage.sv ====
// Access stage; scalar stores write one word only, any non-block store op is treated as a scalar word store
`timescale 1ns/1ps
`default_nettype none

`include "mem_ops.svh"

module mem_access_stage #(
	parameter int LINE_ADDR_BITS = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire lsu_pkg::issue_t issue,
	input wire logic lost,
	output logic ma_req,
	output logic ma_write,
	output lsu_pkg::byte_en_t ma_byte_en,
	output logic [LINE_ADDR_BITS-1:0] ma_line_addr,
	output lsu_pkg::line_t ma_wdata,
	output lsu_pkg::ma_out_t ma
);
	import lsu_pkg::*;

	issue_t inst;
	issue_t inst_next;
	lane_idx_t store_lane;
	logic is_block;

	// Cycle 1 holds the issued instruction
	always_ff @(posedge clk)
	begin
		if (rst)
			inst.valid <= 1'b0;
		else
			inst <= issue;
	end

	assign is_block = `MEM_IS_BLOCK(inst.mem_op);

	// Lowest address word lives in the top lane of the line
	assign store_lane = 4'd15 - inst.address[5:2];

	assign ma_req = inst.valid && (inst.kind == KIND_LOAD || inst.kind == KIND_STORE);
	assign ma_write = inst.kind == KIND_STORE;
	assign ma_line_addr = inst.address[LINE_ADDR_BITS + 5:6];

	// Store data and byte enables
	always_comb
	begin
		ma_byte_en = '0;
		if (is_block)
		begin
			ma_wdata = swap_line(inst.result);
			for (int i = 0; i < 16; i++)
				ma_byte_en[4 * i +: 4] = {4{inst.mask[i]}};
		end
		else
		begin
			ma_wdata = {16{swap_bytes(inst.result[0])}};
			ma_byte_en[4 * store_lane +: 4] = 4'hf;
		end
	end

	// Cycle 2 copy, collision comes from the arbiter's lost flag in that cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			inst_next.valid <= 1'b0;
		else
			inst_next <= inst;
	end

	assign ma.inst = inst_next;
	assign ma.collision = lost;

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
// Fill port always wins the memory; lost is registered and reports a refused access one cycle later
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int LINE_ADDR_BITS = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic ma_req,
	input wire logic ma_write,
	input wire lsu_pkg::byte_en_t ma_byte_en,
	input wire logic [LINE_ADDR_BITS-1:0] ma_line_addr,
	input wire lsu_pkg::line_t ma_wdata,
	input wire logic fill_valid,
	input wire logic [LINE_ADDR_BITS-1:0] fill_line_addr,
	input wire lsu_pkg::line_t fill_data,
	output logic lost,
	output logic mem_req,
	output logic mem_write,
	output lsu_pkg::byte_en_t mem_byte_en,
	output logic [LINE_ADDR_BITS-1:0] mem_line_addr,
	output lsu_pkg::line_t mem_wdata
);

	// Grant within the cycle, fill first
	always_comb
	begin
		if (fill_valid)
		begin
			mem_req = 1'b1;
			mem_write = 1'b1;
			mem_byte_en = '1;
			mem_line_addr = fill_line_addr;
			mem_wdata = fill_data;
		end
		else
		begin
			mem_req = ma_req;
			mem_write = ma_write;
			mem_byte_en = ma_byte_en;
			mem_line_addr = ma_line_addr;
			mem_wdata = ma_wdata;
		end
	end

	// Owner flag of the last cycle the access stage asked for.
	// Set means the fill took it, so the read data does not belong to the access stage
	always_ff @(posedge clk)
	begin
		if (rst)
			lost <= 1'b0;
		else
			lost <= ma_req && fill_valid;
	end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
// Writeback; only scalar loads into register 31 branch, stores retire without a register write
`timescale 1ns/1ps
`default_nettype none

`include "mem_ops.svh"

module writeback_stage (
	input wire logic clk,
	input wire logic rst,
	input wire lsu_pkg::ma_out_t ma,
	input wire lsu_pkg::line_t mem_rdata,
	output lsu_pkg::wb_out_t wb,
	output logic rollback_valid,
	output lsu_pkg::word_t rollback_pc,
	output logic [31:0] retire_count
);
	import lsu_pkg::*;

	issue_t inst;
	lane_idx_t cache_lane;
	word_t lane_value;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;
	word_t aligned_value;
	logic is_load;
	logic is_scalar;
	logic is_block;
	logic rollback_next;
	word_t rollback_pc_next;
	line_t value_next;
	lane_mask_t mask_next;
	logic do_writeback;

	assign inst = ma.inst;
	assign is_load = inst.kind == KIND_LOAD;
	assign is_scalar = `MEM_IS_SCALAR(inst.mem_op);
	assign is_block = `MEM_IS_BLOCK(inst.mem_op);

	// Lane mux, address offset 0 is the top word of the line
	assign cache_lane = 4'd15 - inst.address[5:2];

	always_comb
	begin
		lane_value = mem_rdata[cache_lane];
	end

	always_comb
	begin
		case (inst.address[1:0])
			2'b00: byte_aligned = lane_value[31:24];
			2'b01: byte_aligned = lane_value[23:16];
			2'b10: byte_aligned = lane_value[15:8];
			default: byte_aligned = lane_value[7:0];
		endcase
	end

	// Halfword comes back with its low address byte in the low bits
	always_comb
	begin
		if (inst.address[1])
			half_aligned = {lane_value[7:0], lane_value[15:8]};
		else
			half_aligned = {lane_value[23:16], lane_value[31:24]};
	end

	always_comb
	begin
		case (inst.mem_op)
			`MEM_B: aligned_value = {24'b0, byte_aligned};
			`MEM_BX: aligned_value = {{24{byte_aligned[7]}}, byte_aligned};
			`MEM_S: aligned_value = {16'b0, half_aligned};
			`MEM_SX: aligned_value = {{16{half_aligned[15]}}, half_aligned};
			// Word, and the lane word of strided and gather loads
			default: aligned_value = swap_bytes(lane_value);
		endcase
	end

	// Rollback, a lost memory cycle takes priority over a branch
	always_comb
	begin
		rollback_next = 1'b0;
		rollback_pc_next = '0;
		if (inst.valid && ma.collision)
		begin
			rollback_next = 1'b1;
			rollback_pc_next = inst.pc - 32'd4;
		end
		else if (inst.valid && is_load && is_scalar && !inst.is_vector
			&& inst.dest == 5'd31)
		begin
			// Load into the pc acts as a jump
			rollback_next = 1'b1;
			rollback_pc_next = aligned_value;
		end
	end

	// Writeback source
	always_comb
	begin
		if (is_load && is_scalar)
		begin
			value_next = {16{aligned_value}};
			mask_next = '1;
		end
		else if (is_load && is_block)
		begin
			value_next = swap_line(mem_rdata);
			mask_next = inst.mask;
		end
		else if (is_load)
		begin
			// Strided or gather, one lane per instruction
			value_next = {16{aligned_value}};
			mask_next = (lane_mask_t'(1) << inst.reg_lane) & inst.mask;
		end
		else
		begin
			value_next = inst.result;
			mask_next = inst.mask;
		end
	end

	assign do_writeback = inst.valid && !rollback_next && inst.kind != KIND_STORE;

	always_ff @(posedge clk)
	begin
		wb.dest <= inst.dest;
		wb.is_vector <= inst.is_vector;
		wb.value <= value_next;
		wb.mask <= mask_next;
		rollback_pc <= rollback_pc_next;
		if (rst)
		begin
			wb.valid <= 1'b0;
			rollback_valid <= 1'b0;
		end
		else
		begin
			wb.valid <= do_writeback;
			rollback_valid <= rollback_next;
		end
	end

	// Retired instruction counter
	always_ff @(posedge clk)
	begin
		if (rst)
			retire_count <= '0;
		else if (inst.valid && !rollback_next)
			retire_count <= retire_count + 32'd1;
	end

endmodule

`default_nettype wire

// ==== include/mem_ops.svh ====
// Memory operation codes for the mem_op field; the _M and _IM variants differ only in how issue builds the mask
`ifndef MEM_OPS_SVH
`define MEM_OPS_SVH

// Scalar widths, byte offset taken from address bits 1:0
`define MEM_B          4'b0000
`define MEM_BX         4'b0001
`define MEM_S          4'b0010
`define MEM_SX         4'b0011
`define MEM_L          4'b0100

// Whole line, one word per lane
`define MEM_BLOCK      4'b0111
`define MEM_BLOCK_M    4'b1000
`define MEM_BLOCK_IM   4'b1001

// One lane per instruction, lane picked by reg_lane
`define MEM_STRIDED    4'b1010
`define MEM_STRIDED_M  4'b1011
`define MEM_STRIDED_IM 4'b1100
`define MEM_SCGATH     4'b1101
`define MEM_SCGATH_M   4'b1110
`define MEM_SCGATH_IM  4'b1111

// Class tests
`define MEM_IS_SCALAR(op) ((op) <= `MEM_L)
`define MEM_IS_BLOCK(op) \
	((op) == `MEM_BLOCK || (op) == `MEM_BLOCK_M || (op) == `MEM_BLOCK_IM)

`endif

// ==== src.f ====
+incdir+include
hdl/lsu_pkg.sv
hdl/data_memory.sv
hdl/mem_arbiter.sv
hdl/mem_access_stage.sv
hdl/writeback_stage.sv
hdl/lsu_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== verif/tb_checker.sv ====
// Reference model sampled on rising edges; every line must be filled before it is loaded
`timescale 1ns/1ps
`default_nettype none

`include "mem_ops.svh"

module tb_checker #(
	parameter int LINE_ADDR_BITS = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire lsu_pkg::issue_t issue,
	input wire logic fill_valid,
	input wire logic [LINE_ADDR_BITS-1:0] fill_line_addr,
	input wire lsu_pkg::line_t fill_data,
	input wire lsu_pkg::wb_out_t wb,
	input wire logic rollback_valid,
	input wire lsu_pkg::word_t rollback_pc,
	input wire logic [31:0] retire_count,
	output int error_count,
	output int issued_count,
	output int rollback_count,
	output logic busy
);
	import lsu_pkg::*;

	typedef struct packed
	{
		logic valid;
		word_t pc;
		logic rb_valid;
		word_t rb_pc;
		wb_out_t wb;
	} expect_t;

	// Byte 0 is the lowest address of a line
	logic [7:0] mem_bytes [2 ** LINE_ADDR_BITS][64];
	issue_t s1;
	expect_t p1;
	expect_t p2;
	logic [31:0] retired;

	function automatic logic is_block_op(mem_op_t op);
		return op inside {`MEM_BLOCK, `MEM_BLOCK_M, `MEM_BLOCK_IM};
	endfunction

	// A register holds the lowest address byte in bits 7:0
	function automatic word_t read_word(int line_idx, int word_idx);
		return {mem_bytes[line_idx][4 * word_idx + 3], mem_bytes[line_idx][4 * word_idx + 2],
			mem_bytes[line_idx][4 * word_idx + 1], mem_bytes[line_idx][4 * word_idx]};
	endfunction

	task automatic write_word(int line_idx, int word_idx, word_t value);
		for (int j = 0; j < 4; j++)
			mem_bytes[line_idx][4 * word_idx + j] = value[8 * j +: 8];
	endtask

	task automatic apply_fill(int line_idx, line_t data);
		logic [511:0] flat;
		flat = data;
		// Most significant byte of the fill goes to the lowest address
		for (int b = 0; b < 64; b++)
			mem_bytes[line_idx][b] = flat[511 - 8 * b -: 8];
	endtask

	// Lane i of a vector register maps to word 15 - i of the line
	task automatic apply_store(issue_t inst);
		int line_idx;
		line_idx = inst.address[LINE_ADDR_BITS + 5:6];
		if (is_block_op(inst.mem_op))
		begin
			for (int i = 0; i < 16; i++)
				if (inst.mask[i])
					write_word(line_idx, 15 - i, inst.result[i]);
		end
		else
			write_word(line_idx, inst.address[5:2], inst.result[0]);
	endtask

	function automatic expect_t predict_result(issue_t inst, logic fill);
		expect_t e;
		int line_idx;
		int offset;
		word_t value;
		logic [15:0] half;
		e = '0;
		e.valid = inst.valid;
		e.pc = inst.pc;
		e.wb.dest = inst.dest;
		e.wb.is_vector = inst.is_vector;
		if (!inst.valid)
			return e;
		if (fill && inst.kind != KIND_ARITH)
		begin
			e.rb_valid = 1'b1;
			e.rb_pc = inst.pc - 32'd4;
			return e;
		end
		line_idx = inst.address[LINE_ADDR_BITS + 5:6];
		offset = inst.address[5:0];
		half = {mem_bytes[line_idx][(offset & 62) + 1], mem_bytes[line_idx][offset & 62]};
		case (inst.mem_op)
			`MEM_B: value = {24'b0, mem_bytes[line_idx][offset]};
			`MEM_BX: value = {{24{mem_bytes[line_idx][offset][7]}}, mem_bytes[line_idx][offset]};
			`MEM_S: value = {16'b0, half};
			`MEM_SX: value = {{16{half[15]}}, half};
			default: value = read_word(line_idx, offset / 4);
		endcase
		e.wb.valid = 1'b1;
		e.wb.value = {16{value}};
		e.wb.mask = '1;
		case (inst.kind)
			KIND_ARITH:
			begin
				e.wb.value = inst.result;
				e.wb.mask = inst.mask;
			end
			KIND_LOAD:
			begin
				if (is_block_op(inst.mem_op))
				begin
					for (int i = 0; i < 16; i++)
						e.wb.value[i] = read_word(line_idx, 15 - i);
					e.wb.mask = inst.mask;
				end
				else if (inst.mem_op >= `MEM_STRIDED)
					e.wb.mask = inst.mask & (16'b1 << inst.reg_lane);
				else if (!inst.is_vector && inst.dest == 5'd31)
				begin
					// Scalar load into the pc register branches
					e.wb.valid = 1'b0;
					e.rb_valid = 1'b1;
					e.rb_pc = value;
				end
			end
			default:
				e.wb.valid = 1'b0;
		endcase
		return e;
	endfunction

	task automatic check_outputs(expect_t e);
		if (e.valid && !e.rb_valid)
			retired++;
		if (e.rb_valid)
			rollback_count++;
		if (wb.valid !== e.wb.valid)
		begin
			error_count++;
			if (e.wb.valid)
				$display("writeback missing at %0t for pc %h", $time, e.pc);
			else
				$display("error %0t: unexpected writeback to r%0d", $time, wb.dest);
		end
		else if (e.wb.valid && (wb.dest !== e.wb.dest || wb.is_vector !== e.wb.is_vector
			|| wb.mask !== e.wb.mask || wb.value !== e.wb.value))
		begin
			error_count++;
			$display("error %0t: pc %h wrote r%0d mask %h value %h, expected r%0d mask %h value %h",
				$time, e.pc, wb.dest, wb.mask, wb.value, e.wb.dest, e.wb.mask, e.wb.value);
		end
		if (rollback_valid !== e.rb_valid)
		begin
			error_count++;
			if (e.rb_valid)
				$display("rollback missing at %0t for pc %h", $time, e.pc);
			else
				$display("error %0t: unexpected rollback to %h", $time, rollback_pc);
		end
		else if (e.rb_valid && rollback_pc !== e.rb_pc)
		begin
			error_count++;
			$display("error %0t: pc %h rolled back to %h, expected %h",
				$time, e.pc, rollback_pc, e.rb_pc);
		end
		if (retire_count !== retired)
		begin
			error_count++;
			$display("error %0t: retire_count %0d, expected %0d", $time, retire_count, retired);
		end
	endtask

	// Issue is captured in s1, predicted in its access cycle, compared two edges later
	always @(posedge clk)
	begin
		if (rst)
		begin
			s1 = '0;
			p1 = '0;
			p2 = '0;
			retired = '0;
			error_count = 0;
			issued_count = 0;
			rollback_count = 0;
		end
		else
		begin
			check_outputs(p2);
			p2 = p1;
			p1 = predict_result(s1, fill_valid);
			if (s1.valid && s1.kind == KIND_STORE && !fill_valid)
				apply_store(s1);
			s1 = issue;
			if (issue.valid)
				issued_count++;
		end
		if (fill_valid)
			apply_fill(fill_line_addr, fill_data);
		busy = s1.valid || p1.valid || p2.valid;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// Free running 10 ns clock; reset is high for the first rising edges and drops on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
// Fixed seed random traffic; all lines are filled first, then the hot lines 0 to 7 see mixed traffic
`timescale 1ns/1ps
`default_nettype none

`include "mem_ops.svh"

module tb_top;
	import lsu_pkg::*;

	localparam int LINE_ADDR_BITS = 6;
	localparam int NUM_CYCLES = 2000;
	localparam int WAIT_LIMIT = 50;

	logic clk;
	logic rst;
	issue_t issue;
	logic fill_valid;
	logic [LINE_ADDR_BITS-1:0] fill_line_addr;
	line_t fill_data;
	wb_out_t wb;
	logic rollback_valid;
	word_t rollback_pc;
	logic [31:0] retire_count;
	int error_count;
	int issued_count;
	int rollback_count;
	logic busy;
	int timeouts;
	int final_errors;
	logic [31:0] lfsr;

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	lsu_top #(
		.LINE_ADDR_BITS(LINE_ADDR_BITS)
	) DUT (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.fill_valid(fill_valid),
		.fill_line_addr(fill_line_addr),
		.fill_data(fill_data),
		.wb(wb),
		.rollback_valid(rollback_valid),
		.rollback_pc(rollback_pc),
		.retire_count(retire_count)
	);

	tb_checker #(
		.LINE_ADDR_BITS(LINE_ADDR_BITS)
	) u_checker (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.fill_valid(fill_valid),
		.fill_line_addr(fill_line_addr),
		.fill_data(fill_data),
		.wb(wb),
		.rollback_valid(rollback_valid),
		.rollback_pc(rollback_pc),
		.retire_count(retire_count),
		.error_count(error_count),
		.issued_count(issued_count),
		.rollback_count(rollback_count),
		.busy(busy)
	);

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	function automatic logic [511:0] take_bits(int n);
		logic [511:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return bits;
	endfunction

	// Class 0 is an idle cycle
	task automatic random_issue();
		int kind_sel;
		kind_sel = int'(take_bits(3));
		issue = '0;
		issue.valid = kind_sel != 0;
		issue.kind = KIND_LOAD;
		issue.pc = word_t'(take_bits(32)) & ~32'h3;
		issue.dest = reg_idx_t'(take_bits(5));
		issue.is_vector = kind_sel inside {1, 4, 5, 7};
		issue.mask = lane_mask_t'(take_bits(16));
		issue.result = line_t'(take_bits(512));
		issue.reg_lane = lane_idx_t'(take_bits(4));
		// Few lines in use, so stores and later loads meet
		issue.address = word_t'(take_bits(32)) & ~32'h0000_0e00;
		issue.mem_op = mem_op_t'(take_bits(4));
		case (kind_sel)
			1: issue.kind = KIND_ARITH;
			2, 3:
			begin
				issue.mem_op = mem_op_t'(int'(take_bits(3)) % 5);
				if (kind_sel == 3)
					issue.dest = 5'd31;
			end
			4: issue.mem_op = mem_op_t'(`MEM_BLOCK + int'(take_bits(2)) % 3);
			5: issue.mem_op = mem_op_t'(`MEM_STRIDED + int'(take_bits(3)) % 6);
			6:
			begin
				issue.kind = KIND_STORE;
				issue.mem_op = `MEM_L;
			end
			default:
			begin
				issue.kind = KIND_STORE;
				issue.mem_op = mem_op_t'(`MEM_BLOCK + int'(take_bits(2)) % 3);
			end
		endcase
		// Natural alignment for halfword and word accesses
		if (issue.mem_op inside {`MEM_S, `MEM_SX})
			issue.address[0] = 1'b0;
		else if (!(issue.mem_op inside {`MEM_B, `MEM_BX}))
			issue.address[1:0] = 2'b00;
	endtask

	task automatic random_fill();
		fill_valid = take_bits(3) == 0;
		fill_line_addr = (LINE_ADDR_BITS)'(take_bits(3));
		fill_data = line_t'(take_bits(512));
	endtask

	task automatic wait_reset_release();
		for (int t = 0; t < WAIT_LIMIT; t++)
		begin
			@(posedge clk);
			if (!rst)
				return;
		end
		timeouts++;
		$display("reset was never released");
	endtask

	task automatic wait_drain();
		for (int t = 0; t < WAIT_LIMIT; t++)
		begin
			@(negedge clk);
			if (!busy)
				return;
		end
		timeouts++;
		$display("pipeline did not drain after the last issue");
	endtask

	initial
	begin
		lfsr = 32'hcf5c;
		issue = '0;
		fill_valid = 1'b0;
		fill_line_addr = '0;
		fill_data = '0;
		timeouts = 0;
		final_errors = 0;
		wait_reset_release();
		// Preload every line
		for (int l = 0; l < 2 ** LINE_ADDR_BITS; l++)
		begin
			@(negedge clk);
			fill_valid = 1'b1;
			fill_line_addr = l[LINE_ADDR_BITS-1:0];
			fill_data = line_t'(take_bits(512));
		end
		for (int c = 0; c < NUM_CYCLES; c++)
		begin
			@(negedge clk);
			random_issue();
			random_fill();
		end
		@(negedge clk);
		issue = '0;
		fill_valid = 1'b0;
		wait_drain();
		if (retire_count !== issued_count - rollback_count)
		begin
			final_errors++;
			$display("error %0t: retire_count %0d, expected %0d",
				$time, retire_count, issued_count - rollback_count);
		end
		$display("issued %0d, rollbacks %0d, retired %0d, errors %0d, timeouts %0d",
			issued_count, rollback_count, retire_count, error_count + final_errors, timeouts);
		if (error_count + final_errors + timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
